// ==== rtl/mult_pkg.sv ====
`default_nettype none

package mult_pkg;

    // operand width of each multiply lane
    localparam int OPND_W = 16;

    // full unsigned product, also the memory word
    localparam int PROD_W = 32;

    // two lanes, each owns one half of the product memory
    localparam int NUM_LANES = 2;

    // lanes first, host port last
    localparam int NUM_REQ = NUM_LANES + 1;
    localparam int APB_REQ = NUM_LANES;

    // lane sequencing
    // write collects products, full waits for a block read
    typedef enum logic [1:0] {
        fill_idle  = 2'd0,
        fill_write = 2'd1,
        fill_full  = 2'd2,
        fill_read  = 2'd3
    } fill_state_t;

endpackage

`default_nettype wire

// ==== rtl/mem_req_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface mem_req_if #(
    parameter int LOGDEPTH = 6
);
    import mult_pkg::*;

    // request, held until gnt is seen at an edge
    logic              req;
    logic              we;
    // lanes leave the msb to the arbiter, host drives it
    logic [LOGDEPTH:0] addr;
    logic [PROD_W-1:0] wdata;

    // combinational grant from the arbiter
    logic              gnt;
    // read data, one cycle after the grant
    logic [PROD_W-1:0] rdata;
    logic              rvalid;

    modport requester (
        output req,
        output we,
        output addr,
        output wdata,
        input  gnt,
        input  rdata,
        input  rvalid
    );

    modport arbiter (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output gnt,
        output rdata,
        output rvalid
    );

endinterface

`default_nettype wire

// ==== rtl/mult_fill_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module mult_fill_ctrl #(
    parameter int LOGDEPTH = 6
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          en_mult,
    input  wire  [mult_pkg::OPND_W-1:0]  mult_in_a,
    input  wire  [mult_pkg::OPND_W-1:0]  mult_in_b,
    input  wire                          en_block_read,
    output logic                         rdy_mult,
    output logic                         mem_val_valid,
    output logic [mult_pkg::PROD_W-1:0]  mem_val_data,
    mem_req_if.requester                 mem
);
    import mult_pkg::*;

    fill_state_t         state;
    logic [LOGDEPTH-1:0] wr_idx;
    logic [LOGDEPTH-1:0] rd_idx;
    logic [OPND_W-1:0]   opnd_a;
    logic [OPND_W-1:0]   opnd_b;
    logic [PROD_W-1:0]   product;
    // operands captured, product lands next edge
    logic                mul_pend;
    logic                req_q;
    logic                we_q;
    // last read granted, waiting for its data
    logic                rd_done;
    logic                accept;
    logic                granted;

    assign accept  = rdy_mult && en_mult;
    assign granted = req_q && mem.gnt;

    // operand stage then product stage, no reset on payload
    always_ff @(posedge clk) begin
        if (accept) begin
            opnd_a <= mult_in_a;
            opnd_b <= mult_in_b;
        end
        if (mul_pend) begin
            product <= opnd_a * opnd_b;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= fill_idle;
            wr_idx   <= '0;
            rd_idx   <= '0;
            rdy_mult <= 1'b0;
            mul_pend <= 1'b0;
            req_q    <= 1'b0;
            we_q     <= 1'b0;
            rd_done  <= 1'b0;
        end else begin
            case (state)
                fill_idle: begin
                    // also the first cycle out of reset
                    if (accept) begin
                        rdy_mult <= 1'b0;
                        mul_pend <= 1'b1;
                        state    <= fill_write;
                    end else begin
                        rdy_mult <= 1'b1;
                    end
                end
                fill_write: begin
                    if (accept) begin
                        rdy_mult <= 1'b0;
                        mul_pend <= 1'b1;
                    end
                    // product registered here, write request goes out
                    if (mul_pend) begin
                        mul_pend <= 1'b0;
                        req_q    <= 1'b1;
                        we_q     <= 1'b1;
                    end
                    if (granted) begin
                        req_q <= 1'b0;
                        if (wr_idx == '1) begin
                            wr_idx <= '0;
                            state  <= fill_full;
                        end else begin
                            wr_idx   <= wr_idx + 1'b1;
                            rdy_mult <= 1'b1;
                        end
                    end
                end
                fill_full: begin
                    // half is full, en_mult has no effect here
                    if (en_block_read) begin
                        rd_idx <= '0;
                        req_q  <= 1'b1;
                        we_q   <= 1'b0;
                        state  <= fill_read;
                    end
                end
                fill_read: begin
                    // next index is requested right after each grant
                    if (granted) begin
                        if (rd_idx == '1) begin
                            req_q   <= 1'b0;
                            rd_done <= 1'b1;
                        end else begin
                            rd_idx <= rd_idx + 1'b1;
                        end
                    end
                    if (rd_done && mem.rvalid) begin
                        rd_done  <= 1'b0;
                        rdy_mult <= 1'b1;
                        state    <= fill_idle;
                    end
                end
                default: state <= fill_idle;
            endcase
        end
    end

    assign mem.req   = req_q;
    assign mem.we    = we_q;
    // msb is replaced by the lane index in the arbiter
    assign mem.addr  = {1'b0, ((state == fill_read) ? rd_idx : wr_idx)};
    assign mem.wdata = product;

    // responses only come back for this lane's reads
    assign mem_val_valid = mem.rvalid;
    assign mem_val_data  = mem.rdata;

    // idle lane has no write pending and no read stream running
    a_no_req_in_idle: assert property (
        @(posedge clk) disable iff (rst) (state == fill_idle) |-> !mem.req
    );

    // ready only once the previous product is in memory
    a_rdy_excl_req: assert property (
        @(posedge clk) disable iff (rst) !(rdy_mult && mem.req)
    );

endmodule

`default_nettype wire

// ==== rtl/mem_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter #(
    parameter int LOGDEPTH = 6
) (
    input  wire                          clk,
    input  wire                          rst,
    mem_req_if.arbiter                   req_port [mult_pkg::NUM_REQ],
    output logic                         ram_en,
    output logic                         ram_we,
    output logic [LOGDEPTH:0]            ram_addr,
    output logic [mult_pkg::PROD_W-1:0]  ram_wdata,
    input  wire  [mult_pkg::PROD_W-1:0]  ram_rdata
);
    import mult_pkg::*;

    localparam int SEL_W = $clog2(NUM_REQ);

    logic [NUM_REQ-1:0] req_vec;
    logic [NUM_REQ-1:0] we_vec;
    logic [LOGDEPTH:0]  addr_vec  [NUM_REQ];
    logic [PROD_W-1:0]  wdata_vec [NUM_REQ];
    logic [NUM_REQ-1:0] gnt;
    logic [SEL_W-1:0]   win;
    // requester that won last, lowest priority next
    logic [SEL_W-1:0]   last_q;
    // read grants of the previous cycle
    logic [NUM_REQ-1:0] rd_gnt_q;

    for (genvar i = 0; i < NUM_REQ; i++) begin : g_port
        assign req_vec[i]   = req_port[i].req;
        assign we_vec[i]    = req_port[i].we;
        assign wdata_vec[i] = req_port[i].wdata;
        if (i == APB_REQ) begin : g_host
            // host addresses the whole memory
            assign addr_vec[i] = req_port[i].addr;
        end else begin : g_lane
            // lane index selects the half
            assign addr_vec[i] = {1'(i), req_port[i].addr[LOGDEPTH-1:0]};
        end
        assign req_port[i].gnt    = gnt[i];
        assign req_port[i].rdata  = ram_rdata;
        assign req_port[i].rvalid = rd_gnt_q[i];

        // a waiting requester keeps asking
        a_req_held: assert property (
            @(posedge clk) disable iff (rst) req_vec[i] && !gnt[i] |=> req_vec[i]
        );
    end

    // search starts one past the last winner
    always_comb begin
        int unsigned idx;
        logic        found;
        gnt   = '0;
        win   = last_q;
        found = 1'b0;
        for (int k = 1; k <= NUM_REQ; k++) begin
            idx = (last_q + k) % NUM_REQ;
            if (req_vec[idx] && !found) begin
                gnt[idx] = 1'b1;
                win      = idx[SEL_W-1:0];
                found    = 1'b1;
            end
        end
    end

    assign ram_en    = |gnt;
    assign ram_we    = we_vec[win];
    assign ram_addr  = addr_vec[win];
    assign ram_wdata = wdata_vec[win];

    always_ff @(posedge clk) begin
        if (rst) begin
            // lane 0 goes first out of reset
            last_q   <= SEL_W'(NUM_REQ - 1);
            rd_gnt_q <= '0;
        end else begin
            if (ram_en) begin
                last_q <= win;
            end
            rd_gnt_q <= gnt & ~we_vec;
        end
    end

    // one memory port, one owner
    a_gnt_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot0(gnt)
    );

endmodule

`default_nettype wire

// ==== rtl/product_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module product_ram #(
    parameter int LOGDEPTH = 6
) (
    input  wire                          clk,
    input  wire                          en,
    input  wire                          we,
    input  wire  [LOGDEPTH:0]            addr,
    input  wire  [mult_pkg::PROD_W-1:0]  wdata,
    output logic [mult_pkg::PROD_W-1:0]  rdata
);
    import mult_pkg::*;

    // one half per lane
    localparam int DEPTH = NUM_LANES << LOGDEPTH;

    logic [PROD_W-1:0] mem_q [DEPTH];

    // single port, read data one cycle after the access
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem_q[addr] <= wdata;
            end else begin
                rdata <= mem_q[addr];
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/apb_mem_port.sv ====
`timescale 1ns/100ps
`default_nettype none

module apb_mem_port #(
    parameter int LOGDEPTH = 6
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          psel,
    input  wire                          penable,
    input  wire                          pwrite,
    input  wire  [LOGDEPTH+2:0]          paddr,
    input  wire  [mult_pkg::PROD_W-1:0]  pwdata,
    output logic [mult_pkg::PROD_W-1:0]  prdata,
    output logic                         pready,
    output logic                         pslverr,
    mem_req_if.requester                 mem
);

    logic access;
    logic rd_access;
    logic wr_access;
    // read granted, data due next cycle
    logic rd_inflight;

    assign access    = psel && penable;
    assign rd_access = access && !pwrite;
    assign wr_access = access && pwrite;

    // request from first access cycle until granted
    assign mem.req   = rd_access && !rd_inflight;
    // window is read-only
    assign mem.we    = 1'b0;
    // word index from the byte address
    assign mem.addr  = paddr[LOGDEPTH+2:2];
    assign mem.wdata = pwdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_inflight <= 1'b0;
        end else if (mem.req && mem.gnt) begin
            rd_inflight <= 1'b1;
        end else if (mem.rvalid) begin
            rd_inflight <= 1'b0;
        end
    end

    // reads end with the memory data, writes end at once with an error
    assign prdata  = mem.rdata;
    assign pready  = wr_access || mem.rvalid;
    assign pslverr = wr_access;

    // APB access phase always inside a selected transfer
    a_penable_psel: assert property (
        @(posedge clk) disable iff (rst) penable |-> psel
    );

    // read data routed back only to a read we issued
    a_rvalid_owned: assert property (
        @(posedge clk) disable iff (rst) mem.rvalid |-> rd_inflight
    );

endmodule

`default_nettype wire

// ==== rtl/mult_block_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mult_block_top #(
    parameter int LOGDEPTH = 6
) (
    input  wire                          clk,
    input  wire                          rst,

    // lane 0
    input  wire                          en_mult_0,
    input  wire  [mult_pkg::OPND_W-1:0]  mult_in_a_0,
    input  wire  [mult_pkg::OPND_W-1:0]  mult_in_b_0,
    output logic                         rdy_mult_0,
    input  wire                          en_block_read_0,
    output logic                         mem_val_valid_0,
    output logic [mult_pkg::PROD_W-1:0]  mem_val_data_0,

    // lane 1
    input  wire                          en_mult_1,
    input  wire  [mult_pkg::OPND_W-1:0]  mult_in_a_1,
    input  wire  [mult_pkg::OPND_W-1:0]  mult_in_b_1,
    output logic                         rdy_mult_1,
    input  wire                          en_block_read_1,
    output logic                         mem_val_valid_1,
    output logic [mult_pkg::PROD_W-1:0]  mem_val_data_1,

    // host read port
    input  wire                          psel,
    input  wire                          penable,
    input  wire                          pwrite,
    input  wire  [LOGDEPTH+2:0]          paddr,
    input  wire  [mult_pkg::PROD_W-1:0]  pwdata,
    output logic [mult_pkg::PROD_W-1:0]  prdata,
    output logic                         pready,
    output logic                         pslverr
);
    import mult_pkg::*;

    logic              ram_en;
    logic              ram_we;
    logic [LOGDEPTH:0] ram_addr;
    logic [PROD_W-1:0] ram_wdata;
    logic [PROD_W-1:0] ram_rdata;

    // lanes at 0 and 1, host at APB_REQ
    mem_req_if #(.LOGDEPTH(LOGDEPTH)) req_if [NUM_REQ] ();

    mult_fill_ctrl #(.LOGDEPTH(LOGDEPTH)) lane_0_i (
        .clk           (clk),
        .rst           (rst),
        .en_mult       (en_mult_0),
        .mult_in_a     (mult_in_a_0),
        .mult_in_b     (mult_in_b_0),
        .en_block_read (en_block_read_0),
        .rdy_mult      (rdy_mult_0),
        .mem_val_valid (mem_val_valid_0),
        .mem_val_data  (mem_val_data_0),
        .mem           (req_if[0])
    );

    mult_fill_ctrl #(.LOGDEPTH(LOGDEPTH)) lane_1_i (
        .clk           (clk),
        .rst           (rst),
        .en_mult       (en_mult_1),
        .mult_in_a     (mult_in_a_1),
        .mult_in_b     (mult_in_b_1),
        .en_block_read (en_block_read_1),
        .rdy_mult      (rdy_mult_1),
        .mem_val_valid (mem_val_valid_1),
        .mem_val_data  (mem_val_data_1),
        .mem           (req_if[1])
    );

    apb_mem_port #(.LOGDEPTH(LOGDEPTH)) apb_i (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .mem     (req_if[APB_REQ])
    );

    mem_arbiter #(.LOGDEPTH(LOGDEPTH)) arb_i (
        .clk       (clk),
        .rst       (rst),
        .req_port  (req_if),
        .ram_en    (ram_en),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    product_ram #(.LOGDEPTH(LOGDEPTH)) ram_i (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

`default_nettype wire

// ==== dv/mult_block_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module mult_block_tb;
    import mult_pkg::*;

    localparam int LOGDEPTH = 6;
    localparam int DEPTH    = 1 << LOGDEPTH;
    localparam int WORDS    = NUM_LANES * DEPTH;
    localparam int CLK_NS   = 8;
    // one fill plus its block read, with gaps and contention
    localparam int FILL_CYC  = DEPTH * 12;
    // reset, six fill/read rounds, APB sweeps
    localparam int WORST_CYC = 16 + 6 * FILL_CYC + 4 * WORDS * 8;
    localparam logic [31:0] LFSR_SEED = 32'hcd54_ec72;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic                 clk;
    logic                 rst;
    logic [1:0]           en_mult;
    logic [1:0]           en_block_read;
    logic [OPND_W-1:0]    mult_a [NUM_LANES];
    logic [OPND_W-1:0]    mult_b [NUM_LANES];
    wire  [1:0]           rdy_mult;
    wire  [1:0]           mem_val_valid;
    wire  [PROD_W-1:0]    mem_val_data [NUM_LANES];
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [LOGDEPTH+2:0]  paddr;
    logic [PROD_W-1:0]    pwdata;
    wire  [PROD_W-1:0]    prdata;
    wire                  pready;
    wire                  pslverr;

    // model of the product memory, lane in the top index bit
    logic [PROD_W-1:0]    model_mem [WORDS];
    // value before the latest accept, for reads racing a pending write
    logic [PROD_W-1:0]    old_mem [WORDS];
    logic [LOGDEPTH-1:0]  model_idx [NUM_LANES];
    logic [PROD_W-1:0]    exp_q0 [$];
    logic [PROD_W-1:0]    exp_q1 [$];
    logic [31:0]          lfsr_q;
    int                   mismatches;
    int                   failures;

    mult_block_top #(.LOGDEPTH(LOGDEPTH)) dut_i (
        .clk             (clk),
        .rst             (rst),
        .en_mult_0       (en_mult[0]),
        .mult_in_a_0     (mult_a[0]),
        .mult_in_b_0     (mult_b[0]),
        .rdy_mult_0      (rdy_mult[0]),
        .en_block_read_0 (en_block_read[0]),
        .mem_val_valid_0 (mem_val_valid[0]),
        .mem_val_data_0  (mem_val_data[0]),
        .en_mult_1       (en_mult[1]),
        .mult_in_a_1     (mult_a[1]),
        .mult_in_b_1     (mult_b[1]),
        .rdy_mult_1      (rdy_mult[1]),
        .en_block_read_1 (en_block_read[1]),
        .mem_val_valid_1 (mem_val_valid[1]),
        .mem_val_data_1  (mem_val_data[1]),
        .psel            (psel),
        .penable         (penable),
        .pwrite          (pwrite),
        .paddr           (paddr),
        .pwdata          (pwdata),
        .prdata          (prdata),
        .pready          (pready),
        .pslverr         (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    // unsigned full-width product
    function automatic logic [PROD_W-1:0] ref_product(input logic [OPND_W-1:0] a,
                                                      input logic [OPND_W-1:0] b);
        return PROD_W'(a) * PROD_W'(b);
    endfunction

    function automatic int exp_count(input int lane);
        return (lane == 0) ? exp_q0.size() : exp_q1.size();
    endfunction

    task automatic check_prod(input int lane, input logic [PROD_W-1:0] got,
                              input logic [PROD_W-1:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: lane %0d stream word %h, expected %h",
                     $time, lane, got, exp);
        end
    endtask

    // unwritten words read back as all x, same as the model
    task automatic check_apb_data(input logic [LOGDEPTH:0] idx,
                                  input logic [PROD_W-1:0] got,
                                  input logic [PROD_W-1:0] exp,
                                  input logic [PROD_W-1:0] alt);
        if (got !== exp && got !== alt) begin
            mismatches++;
            $display("mismatch at %0t: APB word %0d read %h, expected %h",
                     $time, idx, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic record_accept(input int lane, input logic [PROD_W-1:0] p);
        logic [LOGDEPTH:0] a;
        a = {lane[0], model_idx[lane]};
        old_mem[a]      = model_mem[a];
        model_mem[a]    = p;
        model_idx[lane] = model_idx[lane] + 1'b1;
        if (lane == 0) begin
            exp_q0.push_back(p);
        end else begin
            exp_q1.push_back(p);
        end
    endtask

    task automatic take_word(input int lane, input logic [PROD_W-1:0] got);
        logic [PROD_W-1:0] e;
        if (exp_count(lane) == 0) begin
            failures++;
            $display("lane %0d streamed a word at %0t that nobody expected", lane, $time);
        end else begin
            if (lane == 0) begin
                e = exp_q0.pop_front();
            end else begin
                e = exp_q1.pop_front();
            end
            check_prod(lane, got, e);
        end
    endtask

    // accepts feed the model, stream words are compared in order
    always @(posedge clk) begin
        if (!rst) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (en_mult[l] && rdy_mult[l]) begin
                    record_accept(l, ref_product(mult_a[l], mult_b[l]));
                end
                if (mem_val_valid[l]) begin
                    take_word(l, mem_val_data[l]);
                end
            end
        end
    end

    task automatic fill_lane(input int lane, input int n, input bit gaps);
        int got;
        got = 0;
        while (got < n) begin
            @(negedge clk);
            if (gaps && take_bits(2) == 0) begin
                en_mult[lane] = 1'b0;
            end else begin
                en_mult[lane] = 1'b1;
                mult_a[lane]  = OPND_W'(take_bits(OPND_W));
                mult_b[lane]  = OPND_W'(take_bits(OPND_W));
            end
            @(posedge clk);
            if (en_mult[lane] && rdy_mult[lane]) begin
                got++;
            end
        end
        @(negedge clk);
        en_mult[lane] = 1'b0;
        // last write lands within one arbiter round
        repeat (NUM_REQ) @(negedge clk);
    endtask

    task automatic start_block_read(input int lane);
        @(negedge clk);
        en_block_read[lane] = 1'b1;
        @(negedge clk);
        en_block_read[lane] = 1'b0;
    endtask

    task automatic wait_stream_done(input int lane);
        int c;
        c = 0;
        while (!(exp_count(lane) == 0 && rdy_mult[lane]) && c < FILL_CYC) begin
            @(negedge clk);
            c++;
        end
        if (c == FILL_CYC) begin
            failures++;
            $display("lane %0d stream did not finish, %0d words still expected",
                     lane, exp_count(lane));
        end
    endtask

    task automatic wait_ready(input int lane);
        int c;
        c = 0;
        while (!rdy_mult[lane] && c < 8) begin
            @(negedge clk);
            c++;
        end
        if (!rdy_mult[lane]) begin
            failures++;
            $display("lane %0d never raised rdy_mult after reset", lane);
        end
    endtask

    task automatic expect_quiet(input int lane, input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            if (mem_val_valid[lane]) begin
                failures++;
                $display("lane %0d streamed at %0t without a full half", lane, $time);
            end
        end
    endtask

    // en_mult pulses while full must change nothing
    task automatic poke_full_lane(input int lane, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            en_mult[lane] = ~en_mult[lane];
            mult_a[lane]  = OPND_W'(take_bits(OPND_W));
            mult_b[lane]  = OPND_W'(take_bits(OPND_W));
            @(posedge clk);
            check_flag(rdy_mult[lane], 1'b0, "rdy_mult of a full lane");
        end
        @(negedge clk);
        en_mult[lane] = 1'b0;
    endtask

    task automatic apb_read(input logic [LOGDEPTH:0] idx, output logic [PROD_W-1:0] data);
        int c;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = {idx, 2'b00};
        @(negedge clk);
        penable = 1'b1;
        c = 0;
        do begin
            @(posedge clk);
            c++;
        end while (!pready && c < FILL_CYC);
        if (!pready) begin
            failures++;
            $display("APB read of word %0d never got pready", idx);
        end
        data = prdata;
        check_flag(pslverr, 1'b0, "pslverr on read");
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [LOGDEPTH:0] idx, input logic [PROD_W-1:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = {idx, 2'b00};
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        // completes in the first access cycle
        @(posedge clk);
        check_flag(pready, 1'b1, "pready on write");
        check_flag(pslverr, 1'b1, "pslverr on write");
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // random reads while lanes are busy, either side of a pending write is fine
    task automatic apb_traffic(input int n);
        logic [LOGDEPTH:0]  idx;
        logic [PROD_W-1:0]  d;
        repeat (n) begin
            idx = (LOGDEPTH+1)'(take_bits(LOGDEPTH + 1));
            apb_read(idx, d);
            check_apb_data(idx, d, model_mem[idx], old_mem[idx]);
        end
    endtask

    task automatic apb_sweep();
        logic [PROD_W-1:0] d;
        for (int i = 0; i < WORDS; i++) begin
            apb_read((LOGDEPTH+1)'(i), d);
            check_apb_data((LOGDEPTH+1)'(i), d, model_mem[i], model_mem[i]);
        end
    endtask

    initial begin
        rst           = 1'b1;
        en_mult       = '0;
        en_block_read = '0;
        mult_a[0]     = '0;
        mult_a[1]     = '0;
        mult_b[0]     = '0;
        mult_b[1]     = '0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        lfsr_q        = LFSR_SEED;
        mismatches    = 0;
        failures      = 0;
        model_idx[0]  = '0;
        model_idx[1]  = '0;
        for (int i = 0; i < WORDS; i++) begin
            model_mem[i] = 'x;
            old_mem[i]   = 'x;
        end

        // reset values, then ready on both lanes
        repeat (16) @(posedge clk);
        check_flag(rdy_mult[0], 1'b0, "rdy_mult_0 in reset");
        check_flag(rdy_mult[1], 1'b0, "rdy_mult_1 in reset");
        check_flag(mem_val_valid[0], 1'b0, "mem_val_valid_0 in reset");
        check_flag(mem_val_valid[1], 1'b0, "mem_val_valid_1 in reset");
        check_flag(pready, 1'b0, "pready in reset");
        @(negedge clk);
        rst = 1'b0;
        wait_ready(0);
        wait_ready(1);

        // lane 0 alone
        fill_lane(0, DEPTH, 1'b0);
        start_block_read(0);
        wait_stream_done(0);

        // both lanes with gaps, host reading alongside
        fork
            fill_lane(0, DEPTH, 1'b1);
            fill_lane(1, DEPTH, 1'b1);
            apb_traffic(24);
        join
        fork
            begin
                start_block_read(0);
                wait_stream_done(0);
            end
            begin
                start_block_read(1);
                wait_stream_done(1);
            end
            apb_traffic(16);
        join

        // block read ignored until full, en_mult ignored while full
        start_block_read(0);
        expect_quiet(0, 8);
        fill_lane(0, 10, 1'b0);
        start_block_read(0);
        expect_quiet(0, 8);
        fill_lane(0, DEPTH - 10, 1'b1);
        poke_full_lane(0, 12);
        start_block_read(0);
        wait_stream_done(0);
        // second fill after a completed stream
        fill_lane(0, DEPTH, 1'b1);
        start_block_read(0);
        wait_stream_done(0);

        // host view of the whole memory, write rejected
        apb_sweep();
        apb_write((LOGDEPTH+1)'(take_bits(LOGDEPTH + 1)), take_bits(PROD_W));
        apb_sweep();

        repeat (4) @(negedge clk);
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // generous bound over the longest sequence of tests
    initial begin
        #(20 * WORST_CYC * CLK_NS);
        $display("timeout: run exceeded %0d clock cycles", 20 * WORST_CYC);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
rtl/mult_pkg.sv
rtl/mem_req_if.sv
rtl/mult_fill_ctrl.sv
rtl/mem_arbiter.sv
rtl/product_ram.sv
rtl/apb_mem_port.sv
rtl/mult_block_top.sv
dv/mult_block_tb.sv
